// File: dv/lsu_tb.sv
//------------------------------------------------------------
// Byte-array model of the low 1 KB, which is what the RAM
// decodes. Responses are checked at the falling edge.
//------------------------------------------------------------
`include "lsu_defs.svh"
`default_nettype none

module lsu_tb;

  import rv32i_types_pkg::*;

  localparam int RESET_CYCLES    = 16;
  localparam int DIRECTED_CYCLES = 200;  // Upper bound for the directed tests.
  localparam int RANDOM_N        = 300;  // Random requests, up to 2 cycles each.
  localparam int CYCLE_LIMIT     = RESET_CYCLES + DIRECTED_CYCLES + 2 * RANDOM_N + 100;

  logic        clk;
  logic        arst_n;
  logic        req;
  logic        is_store;
  load_t       load_type;
  store_t      store_type;
  logic [31:0] base;
  logic [31:0] offset;
  logic [31:0] store_data;
  logic        rsp_valid;
  logic        rsp_fault;
  logic [31:0] load_data;

  logic [7:0]  ref_mem [1024];  // Reference bytes.
  int          exp_due [$];     // Falling-edge index when the response is due.
  logic        exp_fault [$];
  logic [31:0] exp_data [$];
  string       exp_name [$];
  int          neg_count = 0;
  int          cycles = 0;
  int          mismatch_errors = 0;
  int          protocol_errors = 0;
  logic [31:0] lfsr = 32'd99562;
  load_t       load_kinds [5] = '{LB, LH, LW, LBU, LHU};
  store_t      store_kinds [3] = '{SB, SH, SW};

  lsu_top dut_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .req        (req),
    .is_store   (is_store),
    .load_type  (load_type),
    .store_type (store_type),
    .base       (base),
    .offset     (offset),
    .store_data (store_data),
    .rsp_valid  (rsp_valid),
    .rsp_fault  (rsp_fault),
    .load_data  (load_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);  // One step per bit.
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // Predict the response, update the model, then drive one request.
  task automatic issue_request(input logic st, input load_t lt, input store_t stt,
                               input logic [31:0] b, input logic [31:0] o,
                               input logic [31:0] d, input string name);
    logic [31:0] a;
    logic [31:0] val;
    logic        fault;
    int          nb;
    int          idx;
    a = b + o;
    if (st) nb = (stt == SB) ? 1 : (stt == SH) ? 2 : 4;
    else nb = (lt == LB || lt == LBU) ? 1 : (lt == LH || lt == LHU) ? 2 : 4;
    fault = (nb == 2 && a[0]) || (nb == 4 && a[1:0] != 2'b00);
    idx = int'(a[9:0]);  // Higher bits alias.
    val = '0;
    if (!fault && st) begin
      for (int i = 0; i < nb; i++) ref_mem[idx + i] = d[8*i +: 8];
    end else if (!fault) begin
      for (int i = 0; i < nb; i++) val[8*i +: 8] = ref_mem[idx + i];
      if (lt == LB) val = {{24{val[7]}}, val[7:0]};
      if (lt == LH) val = {{16{val[15]}}, val[15:0]};
    end
    @(posedge clk);
    req        <= 1'b1;
    is_store   <= st;
    load_type  <= lt;
    store_type <= stt;
    base       <= b;
    offset     <= o;
    store_data <= d;
    exp_due.push_back(neg_count + 1);  // Next cycle's falling edge.
    exp_fault.push_back(fault);
    exp_data.push_back(val);
    exp_name.push_back(name);
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    req <= 1'b0;
  endtask

  // Response check, away from the rising edge.
  always @(negedge clk) begin
    if (arst_n) begin
      if (exp_due.size() > 0 && exp_due[0] == neg_count) begin
        assert (rsp_valid) else begin
          $display("missing rsp_valid for test %s", exp_name[0]);
          protocol_errors++;
        end
        assert (rsp_fault == exp_fault[0]) else begin
          $display("mismatch %s rsp_fault expected %0b actual %0b",
                   exp_name[0], exp_fault[0], rsp_fault);
          mismatch_errors++;
        end
        assert (load_data == exp_data[0]) else begin
          $display("mismatch %s load_data expected %08h actual %08h",
                   exp_name[0], exp_data[0], load_data);
          mismatch_errors++;
        end
        void'(exp_due.pop_front());
        void'(exp_fault.pop_front());
        void'(exp_data.pop_front());
        void'(exp_name.pop_front());
      end else begin
        assert (!rsp_valid) else begin
          $display("rsp_valid high with no request in the previous cycle");
          protocol_errors++;
        end
      end
    end
    neg_count++;
  end

  // Response strobe is the request strobe one cycle later.
  rsp_follows_req: assert property (@(posedge clk) disable iff (!arst_n)
                                    rsp_valid == $past(req))
    else begin
      $display("rsp_valid does not follow req by exactly one cycle");
      protocol_errors++;
    end

  // Watchdog.
  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, %0d mismatches, %0d protocol errors",
               cycles, mismatch_errors, protocol_errors);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] b;
    logic [31:0] o;
    logic [31:0] d;
    for (int i = 0; i < 1024; i++) ref_mem[i] = 8'h00;  // RAM resets to zero.
    arst_n     = 1'b0;
    req        = 1'b0;
    is_store   = 1'b0;
    load_type  = LW;
    store_type = SW;
    base       = '0;
    offset     = '0;
    store_data = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    assert (!rsp_valid && !rsp_fault) else begin
      $display("response outputs not low after reset");
      protocol_errors++;
    end

    // Word round trip, load on the very next cycle and with a gap.
    issue_request(1, LW, SW, 32'h40, 32'h0, 32'hdeadbeef, "word_store");
    issue_request(0, LW, SW, 32'h30, 32'h10, 32'h0, "word_load_next");
    idle_cycle();
    issue_request(0, LW, SW, 32'h44, 32'hffff_fffc, 32'h0, "word_load_split");
    idle_cycle();

    // Partial stores merge into a known word.
    issue_request(1, LW, SW, 32'h80, 32'h0, 32'h11223344, "merge_seed");
    for (int k = 0; k < 4; k++) begin
      issue_request(1, LW, SB, 32'h80, k, 32'h5a00 + 32'(8'ha0 + k), "merge_sb");
    end
    issue_request(0, LW, SW, 32'h80, 32'h0, 32'h0, "merge_sb_check");
    issue_request(1, LW, SW, 32'h84, 32'h0, 32'h55667788, "merge_seed_h");
    issue_request(1, LW, SH, 32'h84, 32'h2, 32'h1234cafe, "merge_sh_hi");
    issue_request(0, LW, SW, 32'h84, 32'h0, 32'h0, "merge_sh_check");
    issue_request(1, LW, SH, 32'h84, 32'h0, 32'h0000beef, "merge_sh_lo");
    issue_request(0, LW, SW, 32'h84, 32'h0, 32'h0, "merge_sh_check2");
    idle_cycle();

    // Extension at every legal offset.
    issue_request(1, LW, SW, 32'h90, 32'h0, 32'h80ff7f01, "ext_seed_a");
    issue_request(1, LW, SW, 32'h94, 32'h0, 32'h7fff8000, "ext_seed_b");
    for (int w = 0; w < 2; w++) begin
      for (int k = 0; k < 4; k++) begin
        issue_request(0, LB, SW, 32'h90 + 4 * w, k, 32'h0, "ext_lb");
        issue_request(0, LBU, SW, 32'h90 + 4 * w, k, 32'h0, "ext_lbu");
      end
      for (int k = 0; k < 4; k += 2) begin
        issue_request(0, LH, SW, 32'h90 + 4 * w, k, 32'h0, "ext_lh");
        issue_request(0, LHU, SW, 32'h90 + 4 * w, k, 32'h0, "ext_lhu");
      end
    end
    idle_cycle();

    // Misaligned accesses fault and leave memory alone.
    issue_request(1, LW, SW, 32'ha0, 32'h0, 32'h0badf00d, "mal_seed");
    for (int k = 1; k < 4; k += 2) begin
      issue_request(0, LH, SW, 32'ha0, k, 32'h0, "mal_lh");
      issue_request(0, LHU, SW, 32'ha0, k, 32'h0, "mal_lhu");
      issue_request(1, LW, SH, 32'ha0, k, 32'hffffffff, "mal_sh");
    end
    for (int k = 1; k < 4; k++) begin
      issue_request(0, LW, SW, 32'ha0, k, 32'h0, "mal_lw");
      issue_request(1, LW, SW, 32'ha0, k, 32'hffffffff, "mal_sw");
    end
    issue_request(0, LW, SW, 32'ha0, 32'h0, 32'h0, "mal_unchanged");
    idle_cycle();

    // Random mix in a small window from 0x100 to 0x15f.
    for (int n = 0; n < RANDOM_N; n++) begin
      take_bits(1, r);
      take_bits(3, b);
      b = 32'h100 + 8 * b;
      take_bits(5, o);
      take_bits(32, d);
      if (r[0]) begin
        take_bits(2, r);
        issue_request(1, LW, store_kinds[r % 3], b, o, d, "random_store");
      end else begin
        take_bits(3, r);
        issue_request(0, load_kinds[r % 5], SW, b, o, 32'h0, "random_load");
      end
      take_bits(2, r);
      if (r == 0) idle_cycle();  // Occasional gap.
    end
    idle_cycle();
    repeat (3) @(posedge clk);

    if (exp_due.size() != 0) begin
      $display("%0d responses never arrived", exp_due.size());
      protocol_errors++;
    end
    $display("errors: %0d mismatches, %0d protocol errors",
             mismatch_errors, protocol_errors);
    if (mismatch_errors == 0 && protocol_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: lsu.f
+incdir+src
src/rv32i_types_pkg.sv
src/mem_if.sv
src/agu.sv
src/lsu_issue.sv
src/data_ram.sv
src/load_extend.sv
src/lsu_top.sv
dv/lsu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator.
# The run counts as failed if the log holds the fail message.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --timing -Wall -Wno-fatal \
  -f lsu.f --top-module lsu_tb -o lsu_sim > build.log 2>&1 \
  && ./obj_dir/lsu_sim > sim.log 2>&1 \
  && cat sim.log \
  && ! grep -q "Simulation failed" sim.log \
  && grep -q "Simulation completed successfully" sim.log \
  && echo "PASS" \
  || { cat build.log sim.log 2>/dev/null; echo "FAIL"; exit 1; }
exit 0

// File: src/agu.sv
//------------------------------------------------------------
// Purely combinational. Byte enables are 0 on a misaligned
// access; unknown kinds give no lanes and no fault.
//------------------------------------------------------------
`include "lsu_defs.svh"
`default_nettype none

module agu (
  input  logic [`LSU_XLEN-1:0]   port_a,      // Base register.
  input  logic [`LSU_XLEN-1:0]   port_b,      // Offset.
  input  logic                   is_store,
  input  rv32i_types_pkg::load_t  load_type,
  input  rv32i_types_pkg::store_t store_type,
  output logic [`LSU_XLEN-1:0]   address,
  output logic [3:0]             byte_en,
  output logic                   mal_addr
);

  import rv32i_types_pkg::*;

  logic [1:0] byte_offset;  // Lane of the lowest byte.
  logic [3:0] lane_mask;    // Access width as lanes, before shifting.

  // Effective address.
  assign address     = port_a + port_b;
  assign byte_offset = address[1:0];

  // Access width from the load or store kind.
  always_comb begin
    lane_mask = 4'b0000;
    if (is_store) begin
      unique case (store_type)
        SB:      lane_mask = 4'b0001;
        SH:      lane_mask = 4'b0011;
        SW:      lane_mask = 4'b1111;
        default: lane_mask = 4'b0000;  // Reserved encoding.
      endcase
    end else begin
      unique case (load_type)
        LB, LBU: lane_mask = 4'b0001;
        LH, LHU: lane_mask = 4'b0011;
        LW:      lane_mask = 4'b1111;
        default: lane_mask = 4'b0000;
      endcase
    end
  end

  // Alignment check on the lanes actually requested.
  always_comb begin
    if (lane_mask == 4'b1111) begin
      mal_addr = (byte_offset != 2'b00);  // Word needs offset 0.
    end else if (lane_mask == 4'b0011) begin
      mal_addr = byte_offset[0];          // Half-word needs even offset.
    end else begin
      mal_addr = 1'b0;                    // Bytes are always aligned.
    end
  end

  // Shift the lanes up to the addressed byte.
  // A half at offset 2 lands on lanes 2-3, a byte on its one lane.
  assign byte_en = mal_addr ? 4'b0000 : 4'(lane_mask << byte_offset);

endmodule

`default_nettype wire

// File: src/data_ram.sv
//------------------------------------------------------------
// Single port, registered read. A write does not update rdata.
//------------------------------------------------------------
`include "lsu_defs.svh"
`default_nettype none

module data_ram (
  input  logic clk,
  input  logic arst_n,
  mem_if.ram   mem
);

  logic [`LSU_XLEN-1:0] ram_q [`LSU_RAM_WORDS];  // Word storage.

  // Byte-lane writes.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int w = 0; w < `LSU_RAM_WORDS; w++) begin
        ram_q[w] <= '0;  // Contents start at zero.
      end
    end else if (mem.en && mem.we) begin
      for (int b = 0; b < 4; b++) begin
        // Each enabled lane is written on its own.
        if (mem.byte_en[b]) begin
          ram_q[mem.index][8*b +: 8] <= mem.wdata[8*b +: 8];
        end
      end
    end
  end

  // Read port.
  // A load right after a store to the same word
  // sees the new data, as the write landed one edge earlier.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem.rdata <= '0;
    end else if (mem.en && !mem.we) begin
      mem.rdata <= ram_q[mem.index];  // Full word, lanes picked later.
    end
  end

endmodule

`default_nettype wire

// File: src/load_extend.sv
//------------------------------------------------------------
// Combinational. load_data is 0 unless a good load is due.
//------------------------------------------------------------
`include "lsu_defs.svh"
`default_nettype none

module load_extend (
  input  rv32i_types_pkg::pend_t pend,
  input  logic [`LSU_XLEN-1:0]   rdata,
  output logic                   rsp_valid,
  output logic                   rsp_fault,
  output logic [`LSU_XLEN-1:0]   load_data
);

  import rv32i_types_pkg::*;

  logic [`LSU_XLEN-1:0] shifted;   // Addressed data moved to lane 0.
  logic [`LSU_XLEN-1:0] extended;  // After sign or zero extension.
  logic                 good_load;

  // Move the addressed byte or half down to bit 0.
  assign shifted = rdata >> {pend.byte_offset, 3'b000};

  always_comb begin
    unique case (pend.load_type)
      LB:      extended = {{24{shifted[7]}}, shifted[7:0]};    // Sign.
      LH:      extended = {{16{shifted[15]}}, shifted[15:0]};  // Sign.
      LBU:     extended = {24'b0, shifted[7:0]};
      LHU:     extended = {16'b0, shifted[15:0]};
      default: extended = shifted;  // LW, offset is 0 here.
    endcase
  end

  assign good_load = pend.valid & pend.is_load & ~pend.fault;

  assign rsp_valid = pend.valid;
  assign rsp_fault = pend.valid & pend.fault;
  assign load_data = good_load ? extended : '0;  // Stores and faults read 0.

endmodule

`default_nettype wire

// File: src/lsu_defs.svh
//------------------------------------------------------------
// Load/store path sizes. The RAM index is address bits
// [LSU_RAM_AW+1:2], so the address bits above it alias.
//------------------------------------------------------------
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Data and address width.
`define LSU_XLEN 32

// Number of 32-bit words in the local data RAM.
`define LSU_RAM_WORDS 256

// Word index width. Must be log2 of LSU_RAM_WORDS.
`define LSU_RAM_AW 8

`endif

// File: src/lsu_issue.sv
//------------------------------------------------------------
// One request per cycle with req high. Misaligned requests
// never strobe the RAM but still get a response.
//------------------------------------------------------------
`include "lsu_defs.svh"
`default_nettype none

module lsu_issue (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    req,
  input  logic                    is_store,
  input  rv32i_types_pkg::load_t  load_type,
  input  rv32i_types_pkg::store_t store_type,
  input  logic [`LSU_XLEN-1:0]    base,
  input  logic [`LSU_XLEN-1:0]    offset,
  input  logic [`LSU_XLEN-1:0]    store_data,
  mem_if.issuer                   mem,
  output rv32i_types_pkg::pend_t  pend
);

  import rv32i_types_pkg::*;

  logic [`LSU_XLEN-1:0] address;
  logic [3:0]           byte_en;
  logic                 mal_addr;

  // Registered response state.
  logic       valid_q;
  logic       fault_q;
  logic       is_load_q;
  load_t      load_type_q;
  logic [1:0] byte_offset_q;

  agu agu_i (
    .port_a     (base),
    .port_b     (offset),
    .is_store   (is_store),
    .load_type  (load_type),
    .store_type (store_type),
    .address    (address),
    .byte_en    (byte_en),
    .mal_addr   (mal_addr)
  );

  // RAM request, combinational in the request cycle.
  assign mem.en      = req & ~mal_addr;  // Faults never reach memory.
  assign mem.we      = is_store;
  assign mem.index   = address[`LSU_RAM_AW+1:2];  // Upper bits alias.
  assign mem.byte_en = byte_en;

  // Replicate store data so any lane can take it.
  always_comb begin
    unique case (store_type)
      SB:      mem.wdata = {4{store_data[7:0]}};
      SH:      mem.wdata = {2{store_data[15:0]}};
      default: mem.wdata = store_data;  // SW.
    endcase
  end

  // Control bits of the pending response.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
      fault_q <= 1'b0;
    end else begin
      valid_q <= req;             // Every req gets one response.
      fault_q <= req & mal_addr;
    end
  end

  // Payload, only looked at while valid_q is high.
  always_ff @(posedge clk) begin
    is_load_q     <= ~is_store;
    load_type_q   <= load_type;
    byte_offset_q <= address[1:0];
  end

  assign pend = '{
    valid:       valid_q,
    is_load:     is_load_q,
    load_type:   load_type_q,
    byte_offset: byte_offset_q,
    fault:       fault_q
  };

endmodule

`default_nettype wire

// File: src/lsu_top.sv
//------------------------------------------------------------
// Response follows each req by exactly one cycle. No stalls,
// requests may arrive every cycle.
//------------------------------------------------------------
`include "lsu_defs.svh"
`default_nettype none

module lsu_top (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    req,         // One request per high cycle.
  input  logic                    is_store,
  input  rv32i_types_pkg::load_t  load_type,
  input  rv32i_types_pkg::store_t store_type,
  input  logic [`LSU_XLEN-1:0]    base,
  input  logic [`LSU_XLEN-1:0]    offset,
  input  logic [`LSU_XLEN-1:0]    store_data,
  output logic                    rsp_valid,
  output logic                    rsp_fault,
  output logic [`LSU_XLEN-1:0]    load_data
);

  import rv32i_types_pkg::*;

  pend_t pend;  // Issue to response, registered in lsu_issue.

  // RAM port between issue and memory.
  mem_if mem_bus ();

  // Address, lanes and RAM strobe.
  lsu_issue issue_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .req        (req),
    .is_store   (is_store),
    .load_type  (load_type),
    .store_type (store_type),
    .base       (base),
    .offset     (offset),
    .store_data (store_data),
    .mem        (mem_bus.issuer),
    .pend       (pend)
  );

  data_ram ram_i (
    .clk    (clk),
    .arst_n (arst_n),
    .mem    (mem_bus.ram)
  );

  // Lane select and extension on the next cycle.
  load_extend extend_i (
    .pend      (pend),
    .rdata     (mem_bus.rdata),
    .rsp_valid (rsp_valid),
    .rsp_fault (rsp_fault),
    .load_data (load_data)
  );

endmodule

`default_nettype wire

// File: src/mem_if.sv
//------------------------------------------------------------
// Data RAM port. en is a one-cycle strobe, no back-pressure.
//------------------------------------------------------------
`include "lsu_defs.svh"
`default_nettype none

interface mem_if;

  logic                    en;       // Access strobe.
  logic                    we;       // Write when set, else read.
  logic [`LSU_RAM_AW-1:0]  index;    // Word index.
  logic [3:0]              byte_en;  // Lane enables for writes.
  logic [`LSU_XLEN-1:0]    wdata;    // Lane-replicated store data.
  logic [`LSU_XLEN-1:0]    rdata;    // Registered read word.

  // Request side, in lsu_issue.
  modport issuer (
    output en,
    output we,
    output index,
    output byte_en,
    output wdata,
    input  rdata
  );

  // Memory side.
  modport ram (
    input  en,
    input  we,
    input  index,
    input  byte_en,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

// File: src/rv32i_types_pkg.sv
//------------------------------------------------------------
// RV32I load/store kinds use the funct3 encodings.
//------------------------------------------------------------
`default_nettype none

package rv32i_types_pkg;

  // Load kinds, using the funct3 field of the LOAD opcode.
  typedef enum logic [2:0] {
    LB  = 3'b000,  // Signed byte.
    LH  = 3'b001,  // Signed half-word.
    LW  = 3'b010,  // Word.
    LBU = 3'b100,  // Unsigned byte.
    LHU = 3'b101   // Unsigned half-word.
  } load_t;

  // Store kinds, using funct3 of the STORE opcode.
  typedef enum logic [1:0] {
    SB = 2'b00,
    SH = 2'b01,
    SW = 2'b10
  } store_t;

  // State handed from issue to the response stage, one cycle later.
  typedef struct packed {
    logic       valid;        // Response due this cycle.
    logic       is_load;      // Load, so load_data is meaningful.
    load_t      load_type;    // Extension to apply.
    logic [1:0] byte_offset;  // Low address bits of the access.
    logic       fault;        // Misaligned, memory untouched.
  } pend_t;

endpackage

`default_nettype wire
